//--- hw/cache_pkg.sv
package cache_pkg;

	// ------------------------------------------------------------------------
	// slice geometry and replacement
	// ------------------------------------------------------------------------
	localparam int N_LINES = 8;
	localparam int LINE_BW = 3;
	// rrpv of all ones means distant, line may be evicted
	localparam int RRPV_W = 2;
	localparam logic [RRPV_W-1:0] RRPV_INS = 2'd2;

	// ------------------------------------------------------------------------
	// bus widths and ports
	// ------------------------------------------------------------------------
	localparam int ADDR_W = 10;
	localparam int DATA_W = 32;
	// hit counter lives here, never cached
	localparam logic [ADDR_W-1:0] STATUS_ADDR = 10'h3FF;
	localparam int N_PORTS = 2;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic pready;
		logic [DATA_W-1:0] prdata;
	} apb_rsp_t;

	typedef struct packed {
		logic valid;
		logic write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic ready;
		logic [DATA_W-1:0] rdata;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		FILL_REQ,
		FILL_WAIT,
		WT_REQ,
		WT_WAIT,
		RESPOND
	} ctrl_state_e;

	typedef enum logic {
		NOMINAL,
		AGE
	} repl_state_e;

endpackage

//--- hw/srrip_line_controller.sv
`timescale 1ns/10ps

module srrip_line_controller (
	input  logic clock_i,
	input  logic resetn_i,
	// slice select, freezes the block while low
	input  logic enable_i,
	input  logic hit_i,
	input  logic miss_i,
	input  logic [cache_pkg::LINE_BW-1:0] line_i,
	output logic done_o,
	output logic [cache_pkg::LINE_BW-1:0] victim_o
);

	// per line re-reference prediction value
	logic [cache_pkg::RRPV_W-1:0] rrpv_q [cache_pkg::N_LINES];
	// set once a line has been referenced after its fill
	logic [cache_pkg::N_LINES-1:0] first_hit_q;
	cache_pkg::repl_state_e state_q;

	logic [cache_pkg::N_LINES-1:0] distant;
	logic any_distant;
	logic [cache_pkg::LINE_BW-1:0] first_distant;
	logic age_now;

	// ------------------------------------------------------------------------
	// victim search
	// ------------------------------------------------------------------------

	// lowest index at distant rrpv wins, so scan downwards
	always_comb begin
		first_distant = '0;
		for (int i = cache_pkg::N_LINES - 1; i >= 0; i--) begin
			distant[i] = &rrpv_q[i];
			if (distant[i]) begin
				first_distant = cache_pkg::LINE_BW'(i);
			end
		end
		any_distant = |distant;
	end

	// age on a miss with no candidate, and keep ageing until one saturates
	assign age_now = enable_i && !any_distant &&
		((state_q == cache_pkg::NOMINAL && miss_i) || state_q == cache_pkg::AGE);

	// ------------------------------------------------------------------------
	// state and counters
	// ------------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= cache_pkg::NOMINAL;
			done_o <= 1'b0;
			victim_o <= '0;
			first_hit_q <= '0;
			// everything starts distant, so invalid lines fill in index order
			for (int i = 0; i < cache_pkg::N_LINES; i++) begin
				rrpv_q[i] <= '1;
			end
		end else begin
			// done is a single cycle pulse
			done_o <= 1'b0;
			if (enable_i) begin
				case (state_q)
					cache_pkg::NOMINAL: begin
						if (hit_i) begin
							// repeat reference predicts near re-use
							if (first_hit_q[line_i]) begin
								rrpv_q[line_i] <= '0;
							end else begin
								rrpv_q[line_i] <= cache_pkg::RRPV_INS;
								first_hit_q[line_i] <= 1'b1;
							end
						end
						if (miss_i) begin
							if (any_distant) begin
								done_o <= 1'b1;
								victim_o <= first_distant;
								// victim gets refilled, forget its history
								first_hit_q[first_distant] <= 1'b0;
							end else begin
								state_q <= cache_pkg::AGE;
							end
						end
					end
					cache_pkg::AGE: begin
						if (any_distant) begin
							done_o <= 1'b1;
							victim_o <= first_distant;
							first_hit_q[first_distant] <= 1'b0;
							state_q <= cache_pkg::NOMINAL;
						end
					end
					default: state_q <= cache_pkg::NOMINAL;
				endcase

				// one ageing step per cycle, saturated counters stay put
				if (age_now) begin
					for (int i = 0; i < cache_pkg::N_LINES; i++) begin
						if (!distant[i]) begin
							rrpv_q[i] <= rrpv_q[i] + 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

//--- hw/tag_store.sv
`timescale 1ns/10ps

module tag_store (
	input  logic clock_i,
	input  logic resetn_i,
	input  logic [cache_pkg::ADDR_W-1:0] lookup_addr_i,
	output logic hit_o,
	output logic [cache_pkg::LINE_BW-1:0] hit_line_o,
	output logic [cache_pkg::DATA_W-1:0] hit_data_o,
	input  logic wr_en_i,
	input  logic [cache_pkg::LINE_BW-1:0] wr_line_i,
	input  logic [cache_pkg::ADDR_W-1:0] wr_addr_i,
	input  logic [cache_pkg::DATA_W-1:0] wr_data_i
);

	logic [cache_pkg::N_LINES-1:0] valid_q;
	// one word per line, so the whole word address is the tag
	logic [cache_pkg::ADDR_W-1:0] tag_q [cache_pkg::N_LINES];
	logic [cache_pkg::DATA_W-1:0] data_q [cache_pkg::N_LINES];
	logic [cache_pkg::N_LINES-1:0] match;

	// ------------------------------------------------------------------------
	// parallel compare
	// ------------------------------------------------------------------------

	// at most one line matches, so or-ing index and data encodes the one-hot
	always_comb begin
		hit_line_o = '0;
		hit_data_o = '0;
		for (int i = 0; i < cache_pkg::N_LINES; i++) begin
			match[i] = valid_q[i] && (tag_q[i] == lookup_addr_i);
			if (match[i]) begin
				hit_line_o = hit_line_o | cache_pkg::LINE_BW'(i);
				hit_data_o = hit_data_o | data_q[i];
			end
		end
		hit_o = |match;
	end

	// ------------------------------------------------------------------------
	// line update
	// ------------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (wr_en_i) begin
			valid_q[wr_line_i] <= 1'b1;
		end
	end

	// fill or write hit, tag rewrite is harmless on a hit
	always_ff @(posedge clock_i) begin
		if (wr_en_i) begin
			tag_q[wr_line_i] <= wr_addr_i;
			data_q[wr_line_i] <= wr_data_i;
		end
	end

endmodule

//--- hw/cache_controller.sv
`timescale 1ns/10ps

module cache_controller (
	input  logic clock_i,
	input  logic resetn_i,
	input  cache_pkg::apb_req_t apb_i,
	output cache_pkg::apb_rsp_t apb_o,
	output cache_pkg::mem_req_t mem_o,
	input  cache_pkg::mem_rsp_t mem_i
);

	cache_pkg::ctrl_state_e state_q, state_d;
	logic [cache_pkg::DATA_W-1:0] rdata_q;
	logic [cache_pkg::DATA_W-1:0] hit_cnt_q;

	logic lookup_hit;
	logic [cache_pkg::LINE_BW-1:0] lookup_line;
	logic [cache_pkg::DATA_W-1:0] lookup_data;
	logic in_lookup, is_status, fill_done;
	logic ts_wr_en;
	logic [cache_pkg::LINE_BW-1:0] ts_wr_line;
	logic [cache_pkg::DATA_W-1:0] ts_wr_data;
	logic repl_hit, repl_miss, repl_done;
	logic [cache_pkg::LINE_BW-1:0] repl_victim;

	// ------------------------------------------------------------------------
	// lookup decode
	// ------------------------------------------------------------------------
	assign in_lookup = (state_q == cache_pkg::LOOKUP);
	assign is_status = !apb_i.pwrite && (apb_i.paddr == cache_pkg::STATUS_ADDR);
	// status reads stay out of the replacement state
	assign repl_hit = in_lookup && !is_status && lookup_hit;
	// write misses do not allocate
	assign repl_miss = in_lookup && !is_status && !apb_i.pwrite && !lookup_hit;
	assign fill_done = (state_q == cache_pkg::FILL_WAIT) && mem_i.ready;

	// write hit updates its own line, a fill lands in the victim
	assign ts_wr_en = (repl_hit && apb_i.pwrite) || fill_done;
	assign ts_wr_line = fill_done ? repl_victim : lookup_line;
	assign ts_wr_data = fill_done ? mem_i.rdata : apb_i.pwdata;

	tag_store u_tags (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.lookup_addr_i (apb_i.paddr),
		.hit_o         (lookup_hit),
		.hit_line_o    (lookup_line),
		.hit_data_o    (lookup_data),
		.wr_en_i       (ts_wr_en),
		.wr_line_i     (ts_wr_line),
		.wr_addr_i     (apb_i.paddr),
		.wr_data_i     (ts_wr_data)
	);

	// psel acts as the slice select
	srrip_line_controller u_repl (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (apb_i.psel),
		.hit_i    (repl_hit),
		.miss_i   (repl_miss),
		.line_i   (lookup_line),
		.done_o   (repl_done),
		.victim_o (repl_victim)
	);

	// ------------------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::IDLE: if (apb_i.psel && apb_i.penable) state_d = cache_pkg::LOOKUP;
			cache_pkg::LOOKUP: begin
				if (apb_i.pwrite) state_d = cache_pkg::WT_REQ;
				else if (is_status || lookup_hit) state_d = cache_pkg::RESPOND;
				else state_d = cache_pkg::FILL_REQ;
			end
			// victim search runs here, request goes out once it is known
			cache_pkg::FILL_REQ: if (repl_done) state_d = cache_pkg::FILL_WAIT;
			cache_pkg::FILL_WAIT: if (mem_i.ready) state_d = cache_pkg::RESPOND;
			cache_pkg::WT_REQ: state_d = cache_pkg::WT_WAIT;
			cache_pkg::WT_WAIT: if (mem_i.ready) state_d = cache_pkg::RESPOND;
			cache_pkg::RESPOND: state_d = cache_pkg::IDLE;
			default: state_d = cache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= cache_pkg::IDLE;
			hit_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			// read and write hits both count
			if (repl_hit) hit_cnt_q <= hit_cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (in_lookup) rdata_q <= is_status ? hit_cnt_q : lookup_data;
		if (fill_done) rdata_q <= mem_i.rdata;
	end

	// ------------------------------------------------------------------------
	// bus outputs
	// ------------------------------------------------------------------------
	assign apb_o.pready = (state_q == cache_pkg::RESPOND);
	assign apb_o.prdata = rdata_q;

	// valid held through the wait states until ready
	assign mem_o.valid = (state_q == cache_pkg::FILL_WAIT) || (state_q == cache_pkg::WT_REQ) ||
		(state_q == cache_pkg::WT_WAIT);
	assign mem_o.write = (state_q != cache_pkg::FILL_WAIT);
	assign mem_o.addr = apb_i.paddr;
	assign mem_o.wdata = apb_i.pwdata;

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
	input  logic clock_i,
	input  logic resetn_i,
	input  cache_pkg::mem_req_t req_i [cache_pkg::N_PORTS],
	output cache_pkg::mem_rsp_t rsp_o [cache_pkg::N_PORTS],
	output cache_pkg::mem_req_t mem_o,
	input  cache_pkg::mem_rsp_t mem_i
);

	// two ports, so the grant is a single bit
	logic gnt_q;
	logic other;
	logic hand_over;

	assign other = ~gnt_q;

	// ------------------------------------------------------------------------
	// round robin
	// ------------------------------------------------------------------------

	// pass on after the holder's ready, or at once if the holder is idle
	// an idle holder has nothing accepted, so switching cannot cut a transfer
	assign hand_over = req_i[other].valid && (mem_i.ready || !req_i[gnt_q].valid);

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			gnt_q <= 1'b0;
		end else if (hand_over) begin
			gnt_q <= other;
		end
	end

	// ------------------------------------------------------------------------
	// routing
	// ------------------------------------------------------------------------
	assign mem_o = req_i[gnt_q];

	// rdata is shared, only the holder sees ready
	always_comb begin
		for (int p = 0; p < cache_pkg::N_PORTS; p++) begin
			rsp_o[p].ready = mem_i.ready && (gnt_q == 1'(p));
			rsp_o[p].rdata = mem_i.rdata;
		end
	end

endmodule

//--- hw/backing_store.sv
`timescale 1ns/10ps

module backing_store (
	input  logic clock_i,
	input  logic resetn_i,
	input  cache_pkg::mem_req_t req_i,
	output cache_pkg::mem_rsp_t rsp_o
);

	logic [cache_pkg::DATA_W-1:0] mem_q [2**cache_pkg::ADDR_W];
	// per word written flag, unwritten words read as zero
	logic [2**cache_pkg::ADDR_W-1:0] written_q;
	logic ready_q;
	logic [cache_pkg::DATA_W-1:0] rdata_q;
	logic accept;

	// the ready cycle still sees valid, so it must not accept again
	assign accept = req_i.valid && !ready_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			ready_q <= 1'b0;
			written_q <= '0;
		end else begin
			ready_q <= accept;
			if (accept && req_i.write) written_q[req_i.addr] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (accept) begin
			if (req_i.write) mem_q[req_i.addr] <= req_i.wdata;
			rdata_q <= written_q[req_i.addr] ? mem_q[req_i.addr] : '0;
		end
	end

	assign rsp_o.ready = ready_q;
	assign rsp_o.rdata = rdata_q;

endmodule

//--- hw/cache_top.sv
`timescale 1ns/10ps

module cache_top (
	input  logic clock_i,
	input  logic resetn_i,
	input  cache_pkg::apb_req_t apb_i [cache_pkg::N_PORTS],
	output cache_pkg::apb_rsp_t apb_o [cache_pkg::N_PORTS]
);

	// per slice memory bus, before arbitration
	cache_pkg::mem_req_t slice_req [cache_pkg::N_PORTS];
	cache_pkg::mem_rsp_t slice_rsp [cache_pkg::N_PORTS];
	// shared bus into the memory
	cache_pkg::mem_req_t mem_req;
	cache_pkg::mem_rsp_t mem_rsp;

	// ------------------------------------------------------------------------
	// slices
	// ------------------------------------------------------------------------
	for (genvar p = 0; p < cache_pkg::N_PORTS; p++) begin : g_slice
		cache_controller u_slice (
			.clock_i  (clock_i),
			.resetn_i (resetn_i),
			.apb_i    (apb_i[p]),
			.apb_o    (apb_o[p]),
			.mem_o    (slice_req[p]),
			.mem_i    (slice_rsp[p])
		);
	end

	// ------------------------------------------------------------------------
	// shared memory path
	// ------------------------------------------------------------------------
	mem_arbiter u_arb (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.req_i    (slice_req),
		.rsp_o    (slice_rsp),
		.mem_o    (mem_req),
		.mem_i    (mem_rsp)
	);

	backing_store u_mem (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.req_i    (mem_req),
		.rsp_o    (mem_rsp)
	);

endmodule

//--- test/cache_checker.sv
`timescale 1ns/10ps

module cache_checker (
	input  logic clock_i,
	input  logic resetn_i,
	input  cache_pkg::apb_req_t apb_req_i,
	input  cache_pkg::apb_rsp_t apb_rsp_i,
	input  cache_pkg::mem_req_t mem_req_i,
	input  cache_pkg::mem_rsp_t mem_rsp_i
);

	// failures seen by this instance, summed up by the testbench
	int unsigned fail_cnt = 0;

	// ------------------------------------------------------------------------
	// APB side
	// ------------------------------------------------------------------------

	// pready only answers an access phase
	pready_in_access: assert property (@(posedge clock_i) disable iff (!resetn_i)
		apb_rsp_i.pready |-> apb_req_i.psel && apb_req_i.penable)
		else begin
			fail_cnt++;
			$error("pready high outside an APB access phase");
		end

	// single cycle response
	pready_one_cycle: assert property (@(posedge clock_i) disable iff (!resetn_i)
		apb_rsp_i.pready |=> !apb_rsp_i.pready)
		else begin
			fail_cnt++;
			$error("pready held high for more than one cycle");
		end

	// requester holds the transfer until it sees pready
	apb_fields_stable: assert property (@(posedge clock_i) disable iff (!resetn_i)
		apb_req_i.psel && !apb_rsp_i.pready |=> apb_req_i.psel &&
		$stable(apb_req_i.pwrite) && $stable(apb_req_i.paddr) && $stable(apb_req_i.pwdata))
		else begin
			fail_cnt++;
			$error("APB fields changed while the transfer was waiting");
		end

	// ------------------------------------------------------------------------
	// memory side
	// ------------------------------------------------------------------------
	mem_valid_held: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_i.valid && !mem_rsp_i.ready |=> mem_req_i.valid &&
		$stable(mem_req_i.write) && $stable(mem_req_i.addr))
		else begin
			fail_cnt++;
			$error("memory request dropped or changed before ready");
		end

endmodule

//--- test/cache_scoreboard.sv
`timescale 1ns/10ps

module cache_scoreboard (
	input  logic clock_i,
	input  logic resetn_i,
	input  cache_pkg::apb_req_t apb_req_i [cache_pkg::N_PORTS],
	input  cache_pkg::apb_rsp_t apb_rsp_i [cache_pkg::N_PORTS],
	output int unsigned checks_o,
	output int unsigned data_errs_o,
	output int unsigned timing_errs_o
);

	// distant rrpv, a line here may be evicted
	localparam int RRPV_MAX = 3;

	// reference slices, one per port
	int rrpv [cache_pkg::N_PORTS][cache_pkg::N_LINES];
	logic first_hit [cache_pkg::N_PORTS][cache_pkg::N_LINES];
	logic valid [cache_pkg::N_PORTS][cache_pkg::N_LINES];
	logic [cache_pkg::ADDR_W-1:0] tag [cache_pkg::N_PORTS][cache_pkg::N_LINES];
	logic [cache_pkg::DATA_W-1:0] hits [cache_pkg::N_PORTS];
	// shared reference memory, the ports use disjoint ranges
	logic [cache_pkg::DATA_W-1:0] ref_mem [2**cache_pkg::ADDR_W];
	// access phase tracking per port
	logic active [cache_pkg::N_PORTS];
	int wait_cycles [cache_pkg::N_PORTS];

	task automatic clear_model();
		for (int p = 0; p < cache_pkg::N_PORTS; p++) begin
			hits[p] = '0;
			active[p] = 1'b0;
			wait_cycles[p] = 0;
			// all lines invalid and distant
			for (int i = 0; i < cache_pkg::N_LINES; i++) begin
				rrpv[p][i] = RRPV_MAX;
				first_hit[p][i] = 1'b0;
				valid[p][i] = 1'b0;
			end
		end
		for (int a = 0; a < 2**cache_pkg::ADDR_W; a++) begin
			ref_mem[a] = '0;
		end
	endtask

	// ------------------------------------------------------------------------
	// reference model, one completed transfer at a time
	// ------------------------------------------------------------------------
	function automatic logic [cache_pkg::DATA_W-1:0] reference_access(input int p,
		input logic wr, input logic [cache_pkg::ADDR_W-1:0] addr,
		input logic [cache_pkg::DATA_W-1:0] wdata, output logic hit);
		int hit_line;
		int victim;
		logic [cache_pkg::DATA_W-1:0] rd;
		hit = 1'b0;
		hit_line = 0;
		victim = -1;
		// status reads see the count and change nothing
		if (!wr && addr == cache_pkg::STATUS_ADDR) begin
			return hits[p];
		end
		rd = ref_mem[addr];
		for (int i = 0; i < cache_pkg::N_LINES; i++) begin
			if (valid[p][i] && tag[p][i] == addr) begin
				hit = 1'b1;
				hit_line = i;
			end
		end
		if (hit) begin
			hits[p]++;
			// later hits predict near re-use
			if (first_hit[p][hit_line]) begin
				rrpv[p][hit_line] = 0;
			end else begin
				rrpv[p][hit_line] = cache_pkg::RRPV_INS;
				first_hit[p][hit_line] = 1'b1;
			end
		end else if (!wr) begin
			// age all lines until one is distant, lowest index wins
			while (victim < 0) begin
				for (int i = cache_pkg::N_LINES - 1; i >= 0; i--) begin
					if (rrpv[p][i] == RRPV_MAX) begin
						victim = i;
					end
				end
				if (victim < 0) begin
					for (int i = 0; i < cache_pkg::N_LINES; i++) begin
						rrpv[p][i]++;
					end
				end
			end
			// the fill keeps its distant rrpv
			valid[p][victim] = 1'b1;
			tag[p][victim] = addr;
			first_hit[p][victim] = 1'b0;
		end
		// write miss goes to memory only
		if (wr) begin
			ref_mem[addr] = wdata;
		end
		return rd;
	endfunction

	// ------------------------------------------------------------------------
	// compare at mid-cycle, where bus and responses are settled
	// ------------------------------------------------------------------------
	always @(negedge clock_i) begin
		logic [cache_pkg::DATA_W-1:0] exp_data;
		logic hit;
		logic status;
		if (!resetn_i) begin
			clear_model();
		end else begin
			for (int p = 0; p < cache_pkg::N_PORTS; p++) begin
				status = !apb_req_i[p].pwrite && apb_req_i[p].paddr == cache_pkg::STATUS_ADDR;
				if (apb_rsp_i[p].pready && !(apb_req_i[p].psel && apb_req_i[p].penable)) begin
					timing_errs_o++;
					$display("pready on port %0d came outside an access phase", p);
				end
				if (apb_req_i[p].psel && apb_req_i[p].penable) begin
					// first access cycle counts as zero
					if (!active[p]) begin
						active[p] = 1'b1;
						wait_cycles[p] = 0;
					end else begin
						wait_cycles[p]++;
					end
					if (apb_rsp_i[p].pready) begin
						active[p] = 1'b0;
						checks_o++;
						exp_data = reference_access(p, apb_req_i[p].pwrite,
							apb_req_i[p].paddr, apb_req_i[p].pwdata, hit);
						if (!apb_req_i[p].pwrite && apb_rsp_i[p].prdata !== exp_data) begin
							data_errs_o++;
							$display("error prdata port %0d addr %h exp %h got %h", p,
								apb_req_i[p].paddr, exp_data, apb_rsp_i[p].prdata);
						end
						// read hits and status reads answer in two cycles
						if (((hit && !apb_req_i[p].pwrite) || status) && wait_cycles[p] != 2) begin
							timing_errs_o++;
							$display("port %0d answered a hit at %h after %0d cycles, not 2",
								p, apb_req_i[p].paddr, wait_cycles[p]);
						end
					end
				end
			end
		end
	end

endmodule

//--- test/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DELAY = 1;
	localparam int N_TXN = 300;
	// distinct addresses per port, more than the eight lines of a slice
	localparam int WORK_SET = 12;
	localparam int STATUS_EVERY = 50;
	// cycle budget per transfer for the watchdog
	localparam int TXN_CYCLES = 12;

	logic clock;
	logic resetn;
	cache_pkg::apb_req_t apb_req [cache_pkg::N_PORTS];
	cache_pkg::apb_rsp_t apb_rsp [cache_pkg::N_PORTS];
	int unsigned checks;
	int unsigned data_errs;
	int unsigned timing_errs;
	int unsigned assert_fails;

	cache_top dut (
		.clock_i  (clock),
		.resetn_i (resetn),
		.apb_i    (apb_req),
		.apb_o    (apb_rsp)
	);

	cache_scoreboard u_sb (
		.clock_i       (clock),
		.resetn_i      (resetn),
		.apb_req_i     (apb_req),
		.apb_rsp_i     (apb_rsp),
		.checks_o      (checks),
		.data_errs_o   (data_errs),
		.timing_errs_o (timing_errs)
	);

	// handshake assertions in every slice controller
	bind cache_controller cache_checker u_chk (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.apb_req_i (apb_i),
		.apb_rsp_i (apb_o),
		.mem_req_i (mem_o),
		.mem_rsp_i (mem_i)
	);

	assign assert_fails = dut.g_slice[0].u_slice.u_chk.fail_cnt +
		dut.g_slice[1].u_slice.u_chk.fail_cnt;

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// ------------------------------------------------------------------------
	// APB requester
	// ------------------------------------------------------------------------
	task automatic apb_access(input int p, input logic wr,
		input logic [cache_pkg::ADDR_W-1:0] addr, input logic [cache_pkg::DATA_W-1:0] wdata);
		// setup phase
		@(posedge clock);
		#DRIVE_DELAY;
		apb_req[p] = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clock);
		#DRIVE_DELAY;
		apb_req[p].penable = 1'b1;
		// pready is looked at mid-cycle
		do begin
			@(negedge clock);
		end while (!apb_rsp[p].pready);
		@(posedge clock);
		#DRIVE_DELAY;
		apb_req[p] = '0;
	endtask

	task automatic run_port(input int p);
		logic wr;
		logic [cache_pkg::ADDR_W-1:0] addr;
		logic [cache_pkg::DATA_W-1:0] wdata;
		for (int i = 0; i < N_TXN; i++) begin
			// status read first, so the count right after reset is seen
			if (i % STATUS_EVERY == 0) begin
				wr = 1'b0;
				addr = cache_pkg::STATUS_ADDR;
				wdata = '0;
			end else begin
				wr = ($urandom % 10) < 4;
				// port p owns 256 words starting at p * 256
				addr = cache_pkg::ADDR_W'(p * 256 + ($urandom % WORK_SET) * 19);
				wdata = $urandom;
			end
			apb_access(p, wr, addr, wdata);
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(69));
		resetn = 1'b0;
		for (int p = 0; p < cache_pkg::N_PORTS; p++) begin
			apb_req[p] = '0;
		end
		repeat (3) @(posedge clock);
		#DRIVE_DELAY;
		resetn = 1'b1;
		// both ports at once, misses meet at the arbiter
		fork
			run_port(0);
			run_port(1);
		join
		repeat (4) @(posedge clock);
		if (checks != 2 * N_TXN) begin
			$display("only %0d of %0d transfers were checked", checks, 2 * N_TXN);
		end
		$display("checks %0d, data errors %0d, timing errors %0d, assertion failures %0d",
			checks, data_errs, timing_errs, assert_fails);
		if (checks == 2 * N_TXN && data_errs == 0 && timing_errs == 0 && assert_fails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// watchdog over both ports' transfers
	initial begin
		#(2 * N_TXN * TXN_CYCLES * CLK_PERIOD);
		$display("timeout, the transfers did not finish in the allowed time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- cache_srrip.f
hw/cache_pkg.sv
hw/srrip_line_controller.sv
hw/tag_store.sv
hw/cache_controller.sv
hw/mem_arbiter.sv
hw/backing_store.sv
hw/cache_top.sv
test/cache_checker.sv
test/cache_scoreboard.sv
test/cache_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module cache_tb -f cache_srrip.f \
	&& ./obj_dir/Vcache_tb +verilator+error+limit+1000 | tee /dev/stderr \
		| grep -x "RESULT: PASS" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
